// File: rv_pkg.sv
// RV32 execute cluster shared definitions
// Widths, register constants, operation and state encodings

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SP_REG     = 2;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t SP_RST_VAL = 32'hFFFF_FFFF;

    // Decoded instruction at the issue port
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LW,
        OP_SW
    } op_t;

    // ADDI and memory address generation use ALU_ADD
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        WB
    } lsu_state_t;

endpackage

// File: register_file.sv
// RV32 register file, 32 x 32 bits
// Two asynchronous read ports with write bypass, one write port
// x0 reads as zero, stack pointer resets to all ones

`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  logic      wr_en,
    output word_t     rd_data1,
    output word_t     rd_data2
);

    word_t regs [NUM_REGS];
    logic  wr_valid;

    // Writes to x0 are dropped here, so regs[0] holds its reset value
    assign wr_valid = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= (i == SP_REG) ? SP_RST_VAL : '0;
            end
        end else if (wr_valid) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write is forwarded to the readers
    always_comb begin
        if (rd_addr1 == '0) begin
            rd_data1 = '0;
        end else if (wr_valid && (wr_addr == rd_addr1)) begin
            rd_data1 = wr_data;
        end else begin
            rd_data1 = regs[rd_addr1];
        end
    end

    always_comb begin
        if (rd_addr2 == '0) begin
            rd_data2 = '0;
        end else if (wr_valid && (wr_addr == rd_addr2)) begin
            rd_data2 = wr_data;
        end else begin
            rd_data2 = regs[rd_addr2];
        end
    end

endmodule

// File: issue_unit.sv
// Issue stage with busy-bit scoreboard
// Reads operands, stalls on hazards and dispatches to the ALU or the LSU

`timescale 1ns/1ps

module issue_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  op_t       issue_op,
    input  reg_addr_t issue_rd,
    input  reg_addr_t issue_rs1,
    input  reg_addr_t issue_rs2,
    input  word_t     issue_imm,
    input  word_t     rd_data1,
    input  word_t     rd_data2,
    input  logic      alu_can_accept,
    input  logic      lsu_idle,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    output logic      issue_ready,
    output reg_addr_t rd_addr1,
    output reg_addr_t rd_addr2,
    output logic      alu_start,
    output alu_op_t   alu_op,
    output word_t     alu_a,
    output word_t     alu_b,
    output reg_addr_t alu_rd,
    output logic      lsu_start,
    output logic      lsu_load,
    output word_t     lsu_addr,
    output word_t     lsu_wdata,
    output reg_addr_t lsu_rd
);

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] busy_now;
    logic [NUM_REGS-1:0] busy_nxt;
    logic                issue_en;
    logic                uses_rs2;
    logic                writes_rd;
    logic                is_mem;
    logic                hazard;
    logic                fire;

    always_comb begin
        uses_rs2  = 1'b0;
        writes_rd = 1'b1;
        is_mem    = 1'b0;
        alu_op    = ALU_ADD;
        case (issue_op)
            OP_ADD: uses_rs2 = 1'b1;
            OP_SUB: begin
                uses_rs2 = 1'b1;
                alu_op   = ALU_SUB;
            end
            OP_AND: begin
                uses_rs2 = 1'b1;
                alu_op   = ALU_AND;
            end
            OP_OR: begin
                uses_rs2 = 1'b1;
                alu_op   = ALU_OR;
            end
            OP_XOR: begin
                uses_rs2 = 1'b1;
                alu_op   = ALU_XOR;
            end
            OP_SLT: begin
                uses_rs2 = 1'b1;
                alu_op   = ALU_SLT;
            end
            OP_LW: is_mem = 1'b1;
            OP_SW: begin
                uses_rs2  = 1'b1;
                writes_rd = 1'b0;
                is_mem    = 1'b1;
            end
            default: ;
        endcase
    end

    // A register written back this cycle is no longer a hazard, the read bypass covers it
    always_comb begin
        busy_now = busy;
        if (wr_en) begin
            busy_now[wr_addr] = 1'b0;
        end
        busy_nxt = busy_now;
        if (fire && writes_rd) begin
            busy_nxt[issue_rd] = 1'b1;
        end
        busy_nxt[0] = 1'b0;
    end

    assign hazard = busy_now[issue_rs1]
                  | (uses_rs2 & busy_now[issue_rs2])
                  | (writes_rd & busy_now[issue_rd]);

    assign issue_ready = issue_en && !hazard && (is_mem ? lsu_idle : alu_can_accept);
    assign fire        = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= '0;
            issue_en <= 1'b0;
        end else begin
            busy     <= busy_nxt;
            issue_en <= 1'b1;
        end
    end

    assign rd_addr1 = issue_rs1;
    assign rd_addr2 = issue_rs2;

    assign alu_start = fire && !is_mem;
    assign alu_a     = rd_data1;
    assign alu_b     = uses_rs2 ? rd_data2 : issue_imm;
    assign alu_rd    = issue_rd;

    assign lsu_start = fire && is_mem;
    assign lsu_load  = (issue_op == OP_LW);
    assign lsu_addr  = rd_data1 + issue_imm;
    assign lsu_wdata = rd_data2;
    assign lsu_rd    = issue_rd;

endmodule

// File: alu_unit.sv
// ALU execution unit with a single result slot
// Result is requested for writeback the cycle after start

`timescale 1ns/1ps

module alu_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      alu_start,
    input  alu_op_t   alu_op,
    input  word_t     alu_a,
    input  word_t     alu_b,
    input  reg_addr_t alu_rd,
    input  logic      alu_wb_gnt,
    output logic      alu_can_accept,
    output logic      alu_wb_req,
    output reg_addr_t alu_wb_rd,
    output word_t     alu_wb_data
);

    logic  slot_valid;
    word_t result;

    always_comb begin
        case (alu_op)
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR:  result = alu_a | alu_b;
            ALU_XOR: result = alu_a ^ alu_b;
            ALU_SLT: result = word_t'($signed(alu_a) < $signed(alu_b));
            default: result = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (alu_start) begin
            slot_valid <= 1'b1;
        end else if (alu_wb_gnt) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_wb_data <= result;
            alu_wb_rd   <= alu_rd;
        end
    end

    // Slot frees up in the same cycle its result is granted
    assign alu_can_accept = !slot_valid || alu_wb_gnt;
    assign alu_wb_req     = slot_valid;

endmodule

// File: lsu_apb.sv
// Load/store unit acting as an APB master
// One transfer at a time, load data held until writeback is granted

`timescale 1ns/1ps

module lsu_apb import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      lsu_start,
    input  logic      lsu_load,
    input  word_t     lsu_addr,
    input  word_t     lsu_wdata,
    input  reg_addr_t lsu_rd,
    input  word_t     prdata,
    input  logic      pready,
    input  logic      lsu_wb_gnt,
    output logic      lsu_idle,
    output logic      psel,
    output logic      penable,
    output logic      pwrite,
    output word_t     paddr,
    output word_t     pwdata,
    output logic      lsu_wb_req,
    output reg_addr_t lsu_wb_rd,
    output word_t     lsu_wb_data
);

    lsu_state_t state;
    logic       load_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (lsu_start) begin
                        state <= SETUP;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (pready) begin
                        state <= load_q ? WB : IDLE;
                    end
                end
                WB: begin
                    if (lsu_wb_gnt) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request is captured at start and stays put until the next start
    always_ff @(posedge clk) begin
        if (lsu_start && (state == IDLE)) begin
            load_q    <= lsu_load;
            paddr     <= lsu_addr;
            pwdata    <= lsu_wdata;
            lsu_wb_rd <= lsu_rd;
        end
        if ((state == ACCESS) && pready && load_q) begin
            lsu_wb_data <= prdata;
        end
    end

    assign lsu_idle   = (state == IDLE);
    assign psel       = (state == SETUP) || (state == ACCESS);
    assign penable    = (state == ACCESS);
    assign pwrite     = !load_q;
    assign lsu_wb_req = (state == WB);

endmodule

// File: wb_arbiter.sv
// Writeback arbiter for the single register write port
// Fixed priority, LSU over ALU

`timescale 1ns/1ps

module wb_arbiter import rv_pkg::*; (
    input  logic      alu_wb_req,
    input  reg_addr_t alu_wb_rd,
    input  word_t     alu_wb_data,
    input  logic      lsu_wb_req,
    input  reg_addr_t lsu_wb_rd,
    input  word_t     lsu_wb_data,
    output logic      alu_wb_gnt,
    output logic      lsu_wb_gnt,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data
);

    assign lsu_wb_gnt = lsu_wb_req;
    // ALU waits at most one cycle, the LSU cannot request twice in a row
    assign alu_wb_gnt = alu_wb_req && !lsu_wb_req;

    assign wr_en = lsu_wb_gnt || alu_wb_gnt;

    always_comb begin
        if (lsu_wb_req) begin
            wr_addr = lsu_wb_rd;
            wr_data = lsu_wb_data;
        end else begin
            wr_addr = alu_wb_rd;
            wr_data = alu_wb_data;
        end
    end

endmodule

// File: rv_exec_cluster.sv
// RV32 execute and writeback cluster
// Issue unit, ALU and APB load/store unit sharing one register write port

`timescale 1ns/1ps

module rv_exec_cluster import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  op_t       issue_op,
    input  reg_addr_t issue_rd,
    input  reg_addr_t issue_rs1,
    input  reg_addr_t issue_rs2,
    input  word_t     issue_imm,
    output logic      issue_ready,
    output logic      psel,
    output logic      penable,
    output logic      pwrite,
    output word_t     paddr,
    output word_t     pwdata,
    input  word_t     prdata,
    input  logic      pready
);

    reg_addr_t rd_addr1;
    reg_addr_t rd_addr2;
    word_t     rd_data1;
    word_t     rd_data2;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    logic      alu_start;
    alu_op_t   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    reg_addr_t alu_rd;
    logic      alu_can_accept;
    logic      alu_wb_req;
    logic      alu_wb_gnt;
    reg_addr_t alu_wb_rd;
    word_t     alu_wb_data;

    logic      lsu_start;
    logic      lsu_load;
    word_t     lsu_addr;
    word_t     lsu_wdata;
    reg_addr_t lsu_rd;
    logic      lsu_idle;
    logic      lsu_wb_req;
    logic      lsu_wb_gnt;
    reg_addr_t lsu_wb_rd;
    word_t     lsu_wb_data;

    issue_unit issue_unit_i (.*);

    alu_unit alu_unit_i (.*);

    lsu_apb lsu_apb_i (.*);

    wb_arbiter wb_arbiter_i (.*);

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

endmodule

// File: tb_rv_exec_cluster_sva.sv
// Protocol checks for the execute cluster
// APB master timing and writeback arbitration, bound into the cluster

`timescale 1ns/1ps

module tb_rv_exec_cluster_sva import rv_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      psel,
    input logic      penable,
    input logic      pwrite,
    input word_t     paddr,
    input word_t     pwdata,
    input logic      pready,
    input logic      alu_wb_req,
    input logic      alu_wb_gnt,
    input reg_addr_t alu_wb_rd,
    input word_t     alu_wb_data,
    input logic      lsu_wb_req,
    input logic      lsu_wb_gnt
);

    int fail_count = 0;

    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable))
        else begin
            $error("penable rose without a setup cycle");
            fail_count++;
        end

    apb_held: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else begin
            $error("APB address, direction or write data changed inside a transfer");
            fail_count++;
        end

    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_wb_gnt && lsu_wb_gnt))
        else begin
            $error("both writeback grants high in one cycle");
            fail_count++;
        end

    alu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_req && !alu_wb_gnt |=> alu_wb_req && $stable(alu_wb_rd) && $stable(alu_wb_data))
        else begin
            $error("ALU writeback request dropped or changed before grant");
            fail_count++;
        end

    // A load writeback lasts one cycle, so a losing ALU request wins the next one
    alu_wait_bound: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_req && !alu_wb_gnt |-> lsu_wb_req ##1 alu_wb_gnt)
        else begin
            $error("ALU writeback request waited more than one cycle");
            fail_count++;
        end

endmodule

bind rv_exec_cluster tb_rv_exec_cluster_sva sva_i (.*);

// File: tb_rv_exec_cluster.sv
// Testbench for the RV32 execute cluster
// Drives an instruction stream, models APB memory and checks every store against a reference

`timescale 1ns/1ps

module tb_rv_exec_cluster import rv_pkg::*; ();

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    op_t       issue_op;
    reg_addr_t issue_rd;
    reg_addr_t issue_rs1;
    reg_addr_t issue_rs2;
    word_t     issue_imm;
    logic      issue_ready;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;

    integer seed      = 32'hb4222f65;
    int     cycle_cnt = 0;
    int     wait_left = 0;

    // APB slave memory and reference machine state
    word_t mem [64];
    word_t ref_mem [64];
    word_t ref_regs [NUM_REGS];

    // Expected stores in program order
    word_t exp_addr_buf [1024];
    word_t exp_data_buf [1024];
    int    st_wr = 0;
    int    st_rd = 0;
    word_t exp_st_addr;
    word_t exp_st_data;
    logic  store_done;

    op_t alu_ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI};

    rv_exec_cluster rv_exec_cluster_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    // About 300 instructions at up to 12 cycles each, with margin
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == 5000) begin
            stop_with_failure("timeout: the run went past 5000 cycles");
        end
    end

    always @(negedge clk) begin
        if (rv_exec_cluster_i.sva_i.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end
    end

    // APB slave, 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        pready = 1'b0;
        if (psel && !penable) begin
            wait_left = $unsigned($random(seed)) % 4;
        end else if (psel && penable) begin
            if (wait_left == 0) begin
                pready = 1'b1;
                if (pwrite) begin
                    mem[paddr[7:2]] = pwdata;
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
        prdata = mem[paddr[7:2]];
    end

    assign store_done  = psel && penable && pready && pwrite;
    assign exp_st_addr = exp_addr_buf[st_rd];
    assign exp_st_data = exp_data_buf[st_rd];

    always @(posedge clk) begin
        if (store_done) begin
            st_rd <= st_rd + 1;
        end
    end

    store_expected: assert property (@(posedge clk) disable iff (!rst_n)
        store_done |-> (st_rd != st_wr))
        else stop_with_failure("a store reached the APB bus that the program never issued");

    store_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
        store_done && (st_rd != st_wr) |-> (paddr == exp_st_addr))
        else stop_with_failure($sformatf("error at %0d ns: store address expected %h seen %h",
            $time, $sampled(exp_st_addr), $sampled(paddr)));

    store_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        store_done && (st_rd != st_wr) |-> (pwdata == exp_st_data))
        else stop_with_failure($sformatf("error at %0d ns: store data expected %h seen %h",
            $time, $sampled(exp_st_data), $sampled(pwdata)));

    // Every address bit takes part in the pattern
    function automatic word_t fill_word(input int idx);
        word_t addr;
        addr = word_t'(idx) << 2;
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F96;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($random(seed) & 15);
    endfunction

    function automatic word_t rand_addr();
        return word_t'($unsigned($random(seed)) % 64) << 2;
    endfunction

    // Reference update in program order, at acceptance
    task automatic update_model(input op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                                input reg_addr_t rs2, input word_t imm);
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        a    = ref_regs[rs1];
        b    = ref_regs[rs2];
        addr = a + imm;
        res  = '0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + imm;
            OP_LW:   res = ref_mem[addr[7:2]];
            OP_SW: begin
                exp_addr_buf[st_wr] = addr;
                exp_data_buf[st_wr] = b;
                ref_mem[addr[7:2]]  = b;
                st_wr               = st_wr + 1;
            end
            default: ;
        endcase
        if ((op != OP_SW) && (rd != '0)) begin
            ref_regs[rd] = res;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue_instr(input op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                               input reg_addr_t rs2, input word_t imm);
        logic accepted;
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rd    = rd;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_imm   = imm;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = issue_ready;
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b0;
        update_model(op, rd, rs1, rs2, imm);
    endtask

    task automatic store_low_regs(input int base);
        for (int r = 0; r < 16; r++) begin
            issue_instr(OP_SW, '0, '0, reg_addr_t'(r), word_t'(base + 4 * r));
        end
    endtask

    initial begin
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rc;
        op_t       op;

        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        prdata      = '0;
        pready      = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = (i == 2) ? 32'hFFFF_FFFF : 32'h0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state of every register
        for (int i = 0; i < NUM_REGS; i++) begin
            issue_instr(OP_SW, '0, '0, reg_addr_t'(i), word_t'(i * 4));
        end

        repeat (80) begin
            op = alu_ops[$unsigned($random(seed)) % 7];
            issue_instr(op, rand_reg(), rand_reg(), rand_reg(), $random(seed));
        end
        store_low_regs(128);

        // x0 as a target and as a source
        issue_instr(OP_ADDI, '0, 5'd1, '0, 32'h0000_1234);
        issue_instr(OP_XOR, '0, 5'd3, 5'd4, '0);
        issue_instr(OP_LW, '0, '0, '0, 32'd8);
        issue_instr(OP_ADD, 5'd7, '0, 5'd5, '0);
        issue_instr(OP_SW, '0, '0, '0, 32'd200);
        issue_instr(OP_SW, '0, '0, 5'd7, 32'd204);

        // Loads with dependent ops right behind them
        repeat (20) begin
            ra = 5'd1 + reg_addr_t'($unsigned($random(seed)) % 15);
            rb = rand_reg();
            rc = rand_reg();
            issue_instr(OP_LW, ra, '0, '0, rand_addr());
            issue_instr(OP_ADD, rb, ra, rc, '0);
            issue_instr(OP_SW, '0, '0, ra, rand_addr());
            issue_instr(OP_SW, '0, '0, rb, rand_addr());
        end

        // Load followed by an independent ADDI chain, writebacks collide
        repeat (10) begin
            ra = 5'd1 + reg_addr_t'($unsigned($random(seed)) % 7);
            rb = 5'd8 + reg_addr_t'($unsigned($random(seed)) % 8);
            issue_instr(OP_LW, ra, '0, '0, rand_addr());
            repeat (5) begin
                issue_instr(OP_ADDI, rb, rb, '0, $random(seed));
            end
            issue_instr(OP_SW, '0, '0, ra, rand_addr());
            issue_instr(OP_SW, '0, '0, rb, rand_addr());
        end
        store_low_regs(192);

        wait (st_rd == st_wr);
        repeat (2) @(posedge clk);
        if (rv_exec_cluster_i.sva_i.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
rv_pkg.sv
register_file.sv
issue_unit.sv
alu_unit.sv
lsu_apb.sv
wb_arbiter.sv
rv_exec_cluster.sv
tb_rv_exec_cluster_sva.sv
tb_rv_exec_cluster.sv

// File: Bender.yml
package:
  name: rv_exec_cluster

sources:
  - rv_pkg.sv
  - register_file.sv
  - issue_unit.sv
  - alu_unit.sv
  - lsu_apb.sv
  - wb_arbiter.sv
  - rv_exec_cluster.sv
  - target: simulation
    files:
      - tb_rv_exec_cluster_sva.sv
      - tb_rv_exec_cluster.sv
